// File: flist.f
+incdir+verif
hw/dispatchCfgPkg.sv
hw/dispatchPktPkg.sv
hw/dispatchLane.sv
hw/dispatchCapacity.sv
hw/dispatchStage.sv
verif/dispatchTb.sv

// File: hw/dispatchCapacity.sv
// Load/store counting and free-space stall check
`timescale 1ns/1ps

module dispatchCapacity (
  input  logic                                     clk,
  input  logic                                     rstN_i,
  input  logic [dispatchCfgPkg::DISPATCH_WIDTH-1:0] isLoad_i,    // Per-lane load flags
  input  logic [dispatchCfgPkg::DISPATCH_WIDTH-1:0] isStore_i,   // Per-lane store flags
  input  dispatchCfgPkg::lsqCntT                   loadQueueCnt_i,
  input  dispatchCfgPkg::lsqCntT                   storeQueueCnt_i,
  input  dispatchCfgPkg::iqCntT                    issueQueueCnt_i,
  input  dispatchCfgPkg::alCntT                    activeListCnt_i,
  output logic                                     stall_o
);

  import dispatchCfgPkg::*;

  // Extra bit keeps occupancy plus demand from wrapping
  typedef logic [LSQ_CNT_W:0] lsqSumT;
  typedef logic [IQ_CNT_W:0] iqSumT;
  typedef logic [AL_CNT_W:0] alSumT;

  groupCntT loadCnt;
  groupCntT storeCnt;
  lsqSumT   loadDemand;
  lsqSumT   storeDemand;
  iqSumT    iqDemand;
  alSumT    alDemand;
  logic     loadFull;
  logic     storeFull;
  logic     iqFull;
  logic     alFull;

  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int l = 0; l < DISPATCH_WIDTH; l++) begin
      loadCnt  = loadCnt + groupCntT'(isLoad_i[l]);
      storeCnt = storeCnt + groupCntT'(isStore_i[l]);
    end
  end

  assign loadDemand  = lsqSumT'(loadQueueCnt_i) + lsqSumT'(loadCnt);
  assign storeDemand = lsqSumT'(storeQueueCnt_i) + lsqSumT'(storeCnt);
  // IQ and AL reserve a full group regardless of instruction mix
  assign iqDemand    = iqSumT'(issueQueueCnt_i) + iqSumT'(DISPATCH_WIDTH);
  assign alDemand    = alSumT'(activeListCnt_i) + alSumT'(DISPATCH_WIDTH);

  assign loadFull  = loadDemand > lsqSumT'(SIZE_LSQ);    // Exactly full still fits
  assign storeFull = storeDemand > lsqSumT'(SIZE_LSQ);
  assign iqFull    = iqDemand > iqSumT'(SIZE_ISSUEQ);
  assign alFull    = alDemand > alSumT'(SIZE_ACTIVELIST);

  assign stall_o = loadFull | storeFull | iqFull | alFull;

  // Back end must never report more entries than it has
  lsqCntInRange: assert property (
    @(posedge clk) disable iff (!rstN_i)
    loadQueueCnt_i <= lsqCntT'(SIZE_LSQ) && storeQueueCnt_i <= lsqCntT'(SIZE_LSQ)
  ) else $error("Load or store queue count above SIZE_LSQ");

  iqAlCntInRange: assert property (
    @(posedge clk) disable iff (!rstN_i)
    issueQueueCnt_i <= iqCntT'(SIZE_ISSUEQ) && activeListCnt_i <= alCntT'(SIZE_ACTIVELIST)
  ) else $error("Issue queue or active list count above its size");

endmodule

// File: hw/dispatchCfgPkg.sv
// Dispatch configuration package: queue sizes, group width, field widths, count types
package dispatchCfgPkg;

  localparam int DISPATCH_WIDTH = 4;              // Lanes per group, lane 0 oldest
  localparam int CHECKPOINTS = 4;                 // Branch checkpoints in flight
  localparam int CHECKPOINTS_LOG = $clog2(CHECKPOINTS);

  // Back-end structure sizes
  localparam int SIZE_LSQ = 16;                   // Each of load queue and store queue
  localparam int SIZE_ISSUEQ = 32;
  localparam int SIZE_ACTIVELIST = 64;

  // Instruction field widths
  localparam int SIZE_PHYSICAL_LOG = 6;           // Physical register tag
  localparam int SIZE_RMT_LOG = 5;                // Architectural register
  localparam int SIZE_OPCODE = 8;
  localparam int SIZE_PC = 16;

  // Counters hold 0..size inclusive, hence the +1
  localparam int LSQ_CNT_W = $clog2(SIZE_LSQ + 1);
  localparam int IQ_CNT_W = $clog2(SIZE_ISSUEQ + 1);
  localparam int AL_CNT_W = $clog2(SIZE_ACTIVELIST + 1);
  localparam int GROUP_CNT_W = $clog2(DISPATCH_WIDTH + 1);

  typedef logic [CHECKPOINTS_LOG-1:0] checkpointIdT;  // Checkpoint index
  typedef logic [CHECKPOINTS-1:0] branchMaskT;        // One bit per checkpoint

  typedef logic [LSQ_CNT_W-1:0] lsqCntT;              // 0..SIZE_LSQ
  typedef logic [IQ_CNT_W-1:0] iqCntT;                // 0..SIZE_ISSUEQ
  typedef logic [AL_CNT_W-1:0] alCntT;                // 0..SIZE_ACTIVELIST
  typedef logic [GROUP_CNT_W-1:0] groupCntT;          // 0..DISPATCH_WIDTH

endpackage

// File: hw/dispatchLane.sv
// Per-lane branch-mask update and issue/active-list/LSQ packet formation
`timescale 1ns/1ps

module dispatchLane (
  input  logic                        clk,
  input  logic                        rstN_i,
  input  dispatchPktPkg::renamedPktT  renamedPkt_i,
  input  logic                        ctrlVerified_i,      // A branch resolved correctly
  input  dispatchCfgPkg::checkpointIdT ctrlVerifiedId_i,   // Its checkpoint
  output dispatchPktPkg::iqPktT       iqPkt_o,
  output dispatchPktPkg::alPktT       alPkt_o,
  output dispatchPktPkg::lsqPktT      lsqPkt_o,
  output dispatchCfgPkg::branchMaskT  updatedBranchMask_o
);

  import dispatchCfgPkg::*;
  import dispatchPktPkg::*;

  branchMaskT clearMask;  // One-hot bit of the verified checkpoint

  assign clearMask = ctrlVerified_i ? (branchMaskT'(1'b1) << ctrlVerifiedId_i) : '0;

  // Verified branch no longer guards this instruction
  assign updatedBranchMask_o = renamedPkt_i.branchMask & ~clearMask;

  assign iqPkt_o = iqPktT'{
    destValid:    renamedPkt_i.destValid,
    isStore:      renamedPkt_i.isStore,
    isLoad:       renamedPkt_i.isLoad,
    branchMask:   updatedBranchMask_o,
    checkpointId: renamedPkt_i.checkpointId,
    phySrc1:      renamedPkt_i.phySrc1,
    phySrc2:      renamedPkt_i.phySrc2,
    phyDest:      renamedPkt_i.phyDest,
    opcode:       renamedPkt_i.opcode,
    pc:           renamedPkt_i.pc
  };

  // Retire needs the old mapping to free it
  assign alPkt_o = alPktT'{
    isLoad:     renamedPkt_i.isLoad,
    isStore:    renamedPkt_i.isStore,
    pc:         renamedPkt_i.pc,
    archDest:   renamedPkt_i.archDest,
    phyDest:    renamedPkt_i.phyDest,
    oldPhyDest: renamedPkt_i.oldPhyDest,
    destValid:  renamedPkt_i.destValid
  };

  assign lsqPkt_o = lsqPktT'{
    branchMask: updatedBranchMask_o,
    isStore:    renamedPkt_i.isStore,
    isLoad:     renamedPkt_i.isLoad
  };

  // Mask update may only drop dependences, never add one
  maskOnlyClears: assert property (
    @(posedge clk) disable iff (!rstN_i)
    (updatedBranchMask_o & ~renamedPkt_i.branchMask) == '0
  ) else $error("Lane mask gained a bit the renamed packet lacked");

endmodule

// File: hw/dispatchPktPkg.sv
// Packet formats: renamed, issue-queue, active-list and load-store-queue packets
package dispatchPktPkg;

  import dispatchCfgPkg::*;

  // Packet coming out of the rename/dispatch pipeline register
  typedef struct packed {
    logic [SIZE_RMT_LOG-1:0]      archDest;
    logic                         destValid;
    logic                         isStore;
    logic                         isLoad;
    branchMaskT                   branchMask;   // Unresolved branches this instr depends on
    checkpointIdT                 checkpointId;
    logic [SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic [SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic [SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [SIZE_PHYSICAL_LOG-1:0] oldPhyDest;   // Previous mapping, freed at retire
    logic [SIZE_OPCODE-1:0]       opcode;
    logic [SIZE_PC-1:0]           pc;
  } renamedPktT;

  // Issue queue entry
  typedef struct packed {
    logic                         destValid;
    logic                         isStore;
    logic                         isLoad;
    branchMaskT                   branchMask;   // Already cleared of the verified branch
    checkpointIdT                 checkpointId;
    logic [SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic [SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic [SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [SIZE_OPCODE-1:0]       opcode;
    logic [SIZE_PC-1:0]           pc;
  } iqPktT;

  // Active list entry
  typedef struct packed {
    logic                         isLoad;
    logic                         isStore;
    logic [SIZE_PC-1:0]           pc;
    logic [SIZE_RMT_LOG-1:0]      archDest;
    logic [SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [SIZE_PHYSICAL_LOG-1:0] oldPhyDest;
    logic                         destValid;
  } alPktT;

  // Load-store queue entry
  typedef struct packed {
    branchMaskT branchMask;
    logic       isStore;
    logic       isLoad;
  } lsqPktT;

endpackage

// File: hw/dispatchStage.sv
// Dispatch top level: four dispatch lanes, capacity check and back-end/front-end handshake
`timescale 1ns/1ps

module dispatchStage (
  input  logic                         clk,
  input  logic                         rstN_i,
  input  logic                         renameReady_i,    // Rename holds a valid group
  input  logic                         flagRecoverEX_i,  // Mispredict recovery in progress
  input  logic                         ctrlVerified_i,
  input  dispatchCfgPkg::checkpointIdT ctrlVerifiedId_i,

  input  dispatchPktPkg::renamedPktT   renamedPkt_i [dispatchCfgPkg::DISPATCH_WIDTH],

  // Occupancy reported by the back end
  input  dispatchCfgPkg::lsqCntT       loadQueueCnt_i,
  input  dispatchCfgPkg::lsqCntT       storeQueueCnt_i,
  input  dispatchCfgPkg::iqCntT        issueQueueCnt_i,
  input  dispatchCfgPkg::alCntT        activeListCnt_i,

  output dispatchPktPkg::iqPktT        iqPkt_o [dispatchCfgPkg::DISPATCH_WIDTH],
  output dispatchPktPkg::alPktT        alPkt_o [dispatchCfgPkg::DISPATCH_WIDTH],
  output dispatchPktPkg::lsqPktT       lsqPkt_o [dispatchCfgPkg::DISPATCH_WIDTH],
  // Written back to the rename/dispatch register while the group waits
  output dispatchCfgPkg::branchMaskT   updatedBranchMask_o [dispatchCfgPkg::DISPATCH_WIDTH],

  output logic                         backEndReady_o,   // Back end takes the group
  output logic                         stallFrontEnd_o   // Hold decode and rename
);

  import dispatchCfgPkg::*;

  logic [DISPATCH_WIDTH-1:0] laneIsLoad;
  logic [DISPATCH_WIDTH-1:0] laneIsStore;
  logic                      stall;

  for (genvar l = 0; l < DISPATCH_WIDTH; l++) begin : genLane
    dispatchLane dispatchLane_i (
      .clk                 (clk),
      .rstN_i              (rstN_i),
      .renamedPkt_i        (renamedPkt_i[l]),
      .ctrlVerified_i      (ctrlVerified_i),
      .ctrlVerifiedId_i    (ctrlVerifiedId_i),
      .iqPkt_o             (iqPkt_o[l]),
      .alPkt_o             (alPkt_o[l]),
      .lsqPkt_o            (lsqPkt_o[l]),
      .updatedBranchMask_o (updatedBranchMask_o[l])
    );

    assign laneIsLoad[l]  = renamedPkt_i[l].isLoad;
    assign laneIsStore[l] = renamedPkt_i[l].isStore;  // Each lane's own store flag
  end

  dispatchCapacity dispatchCapacity_i (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .isLoad_i        (laneIsLoad),
    .isStore_i       (laneIsStore),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .stall_o         (stall)
  );

  // Front end stalls on lack of room even when rename has nothing to send
  assign stallFrontEnd_o = stall;
  assign backEndReady_o  = renameReady_i & ~stall & ~flagRecoverEX_i;

  // The back end must not latch a group the queues cannot hold
  noAcceptOnStall: assert property (
    @(posedge clk) disable iff (!rstN_i)
    !(backEndReady_o && stallFrontEnd_o)
  ) else $error("backEndReady_o high while the front end is stalled");

endmodule

// File: runSim.sh
#!/bin/sh
# Builds the dispatch stage testbench with Verilator and runs it from the project root

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=dispatchSim
LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module dispatchTb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The testbench verdict decides the exit status
if grep -q '\*\* FAIL \*\*' "$LOG"; then
  echo "Testbench reported failure, see $LOG"
  exit 1
fi

exit 0

// File: verif/dispatchChecks.svh
// Reference model for dispatch packets and typed compare tasks for dispatchTb
`ifndef DISPATCH_CHECKS_SVH
`define DISPATCH_CHECKS_SVH

  // Clears bit id when a branch is verified, every other bit kept
  function automatic branchMaskT expMask(branchMaskT m, logic verified, checkpointIdT id);
    branchMaskT r;
    r = m;
    for (int b = 0; b < CHECKPOINTS; b++) begin
      if (verified && b == int'(id)) r[b] = 1'b0;
    end
    return r;
  endfunction

  function automatic iqPktT expIq(renamedPktT p, logic verified, checkpointIdT id);
    iqPktT e;
    e.destValid    = p.destValid;
    e.isStore      = p.isStore;
    e.isLoad       = p.isLoad;
    e.branchMask   = expMask(p.branchMask, verified, id);
    e.checkpointId = p.checkpointId;
    e.phySrc1      = p.phySrc1;
    e.phySrc2      = p.phySrc2;
    e.phyDest      = p.phyDest;
    e.opcode       = p.opcode;
    e.pc           = p.pc;
    return e;
  endfunction

  function automatic alPktT expAl(renamedPktT p);
    alPktT e;
    e.isLoad     = p.isLoad;
    e.isStore    = p.isStore;
    e.pc         = p.pc;
    e.archDest   = p.archDest;
    e.phyDest    = p.phyDest;
    e.oldPhyDest = p.oldPhyDest;  // Freed at retire
    e.destValid  = p.destValid;
    return e;
  endfunction

  function automatic lsqPktT expLsq(renamedPktT p, logic verified, checkpointIdT id);
    lsqPktT e;
    e.branchMask = expMask(p.branchMask, verified, id);
    e.isStore    = p.isStore;
    e.isLoad     = p.isLoad;
    return e;
  endfunction

  task automatic compareIq(int lane, iqPktT got, iqPktT exp);
    if (got !== exp) begin
      pktErrors++;
      $display("[FAIL] t=%0d ns: lane %0d issue-queue packet %h, expected %h",
               $time, lane, got, exp);
    end
  endtask

  task automatic compareAl(int lane, alPktT got, alPktT exp);
    if (got !== exp) begin
      pktErrors++;
      $display("[FAIL] t=%0d ns: lane %0d active-list packet %h, expected %h",
               $time, lane, got, exp);
    end
  endtask

  task automatic compareLsq(int lane, lsqPktT got, lsqPktT exp);
    if (got !== exp) begin
      pktErrors++;
      $display("[FAIL] t=%0d ns: lane %0d load-store-queue packet %h, expected %h",
               $time, lane, got, exp);
    end
  endtask

  task automatic compareMask(int lane, branchMaskT got, branchMaskT exp);
    if (got !== exp) begin
      maskErrors++;
      $display("[FAIL] t=%0d ns: lane %0d updated branch mask %b, expected %b",
               $time, lane, got, exp);
    end
  endtask

  task automatic compareCtrl(string name, logic got, logic exp);
    if (got !== exp) begin
      ctrlErrors++;
      $display("[FAIL] t=%0d ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

`endif

// File: verif/dispatchTb.sv
// Testbench for dispatchStage: clock, reset, trace-driven stimulus, watchdog and report
`timescale 1ns/1ps

module dispatchTb;

  import dispatchCfgPkg::*;
  import dispatchPktPkg::*;

  localparam int CLK_PERIOD = 4;
  localparam string TRACE_PATH = "verif/dispatchTrace.txt";

  // One trace line as stimulus plus expected control outputs
  typedef struct packed {
    logic                      renameReady;
    logic                      flagRecover;
    logic                      ctrlVerified;
    checkpointIdT              verifiedId;
    lsqCntT                    loadCnt;
    lsqCntT                    storeCnt;
    iqCntT                     iqCnt;
    alCntT                     alCnt;
    logic [DISPATCH_WIDTH-1:0] loadMask;
    logic [DISPATCH_WIDTH-1:0] storeMask;
    logic                      expReady;
    logic                      expStall;
  } traceLineT;

  logic         clk;
  logic         rstN;
  logic         renameReady;
  logic         flagRecoverEX;
  logic         ctrlVerified;
  checkpointIdT ctrlVerifiedId;
  renamedPktT   renamedPkt [DISPATCH_WIDTH];
  lsqCntT       loadQueueCnt;
  lsqCntT       storeQueueCnt;
  iqCntT        issueQueueCnt;
  alCntT        activeListCnt;
  iqPktT        iqPkt [DISPATCH_WIDTH];
  alPktT        alPkt [DISPATCH_WIDTH];
  lsqPktT       lsqPkt [DISPATCH_WIDTH];
  branchMaskT   updatedBranchMask [DISPATCH_WIDTH];
  logic         backEndReady;
  logic         stallFrontEnd;

  traceLineT traceQ [$];
  int        seed = 385;      // Random packet fields
  int        watchdogNs = 0;  // Armed once the trace length is known
  int        pktErrors = 0;
  int        maskErrors = 0;
  int        ctrlErrors = 0;
  int        traceErrors = 0;

  `include "dispatchChecks.svh"

  dispatchStage dispatchStage_i (
    .clk                 (clk),
    .rstN_i              (rstN),
    .renameReady_i       (renameReady),
    .flagRecoverEX_i     (flagRecoverEX),
    .ctrlVerified_i      (ctrlVerified),
    .ctrlVerifiedId_i    (ctrlVerifiedId),
    .renamedPkt_i        (renamedPkt),
    .loadQueueCnt_i      (loadQueueCnt),
    .storeQueueCnt_i     (storeQueueCnt),
    .issueQueueCnt_i     (issueQueueCnt),
    .activeListCnt_i     (activeListCnt),
    .iqPkt_o             (iqPkt),
    .alPkt_o             (alPkt),
    .lsqPkt_o            (lsqPkt),
    .updatedBranchMask_o (updatedBranchMask),
    .backEndReady_o      (backEndReady),
    .stallFrontEnd_o     (stallFrontEnd)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic loadTrace();
    int        fd;
    int        n;
    string     line;
    int        rr, fr, cv, id, ld, st, iq, al, lm, sm, er, es;
    traceLineT t;
    fd = $fopen(TRACE_PATH, "r");
    if (fd == 0) begin
      $display("Cannot open trace file %s, no stimulus available", TRACE_PATH);
      traceErrors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.substr(0, 0) == "#") continue;  // Blank or comment
        n = $sscanf(line, "%d %d %d %d %d %d %d %d %b %b %d %d",
                    rr, fr, cv, id, ld, st, iq, al, lm, sm, er, es);
        if (n != 12) begin
          $display("Trace line could not be parsed: %s", line);
          traceErrors++;
        end else begin
          t.renameReady  = rr[0];
          t.flagRecover  = fr[0];
          t.ctrlVerified = cv[0];
          t.verifiedId   = checkpointIdT'(id);
          t.loadCnt      = lsqCntT'(ld);
          t.storeCnt     = lsqCntT'(st);
          t.iqCnt        = iqCntT'(iq);
          t.alCnt        = alCntT'(al);
          t.loadMask     = lm[DISPATCH_WIDTH-1:0];
          t.storeMask    = sm[DISPATCH_WIDTH-1:0];
          t.expReady     = er[0];
          t.expStall     = es[0];
          traceQ.push_back(t);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic driveLine(traceLineT t);
    logic [63:0] r;
    renameReady    = t.renameReady;
    flagRecoverEX  = t.flagRecover;
    ctrlVerified   = t.ctrlVerified;
    ctrlVerifiedId = t.verifiedId;
    loadQueueCnt   = t.loadCnt;
    storeQueueCnt  = t.storeCnt;
    issueQueueCnt  = t.iqCnt;
    activeListCnt  = t.alCnt;
    for (int l = 0; l < DISPATCH_WIDTH; l++) begin
      r = {$random(seed), $random(seed)};
      renamedPkt[l] = r[$bits(renamedPktT)-1:0];
      renamedPkt[l].isLoad  = t.loadMask[l];   // Load/store mix set by the trace
      renamedPkt[l].isStore = t.storeMask[l];
    end
  endtask

  task automatic checkLine(traceLineT t);
    for (int l = 0; l < DISPATCH_WIDTH; l++) begin
      compareIq(l, iqPkt[l], expIq(renamedPkt[l], ctrlVerified, ctrlVerifiedId));
      compareAl(l, alPkt[l], expAl(renamedPkt[l]));
      compareLsq(l, lsqPkt[l], expLsq(renamedPkt[l], ctrlVerified, ctrlVerifiedId));
      compareMask(l, updatedBranchMask[l],
                  expMask(renamedPkt[l].branchMask, ctrlVerified, ctrlVerifiedId));
    end
    compareCtrl("backEndReady_o", backEndReady, t.expReady);
    compareCtrl("stallFrontEnd_o", stallFrontEnd, t.expStall);
  endtask

  initial begin
    rstN           = 1'b0;
    renameReady    = 1'b0;
    flagRecoverEX  = 1'b0;
    ctrlVerified   = 1'b0;
    ctrlVerifiedId = '0;
    loadQueueCnt   = '0;
    storeQueueCnt  = '0;
    issueQueueCnt  = '0;
    activeListCnt  = '0;
    for (int l = 0; l < DISPATCH_WIDTH; l++) renamedPkt[l] = '0;
    loadTrace();
    if (traceQ.size() == 0) begin
      $display("The trace holds no test lines, nothing was checked");
      traceErrors++;
    end else begin
      watchdogNs = (traceQ.size() + 10) * CLK_PERIOD;
      repeat (2) @(posedge clk);
      #1 rstN = 1'b1;
      foreach (traceQ[i]) begin
        @(posedge clk);
        #1 driveLine(traceQ[i]);
        #2 checkLine(traceQ[i]);  // 1 ns before the next edge
      end
    end
    $display("Errors: packet %0d, mask %0d, control %0d, trace %0d",
             pktErrors, maskErrors, ctrlErrors, traceErrors);
    if (pktErrors + maskErrors + ctrlErrors + traceErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Ends a run that stops making progress
  initial begin
    wait (watchdogNs > 0);
    #(watchdogNs);
    $display("Timeout after %0d ns, the trace did not run to its end", watchdogNs);
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: verif/dispatchTrace.txt
# renameReady flagRecoverEX ctrlVerified verifiedId loadCnt storeCnt iqCnt alCnt
# loadMask(bin, lane 3..0) storeMask(bin) expBackEndReady expStallFrontEnd
1 0 0 0 0 0 0 0 0000 0000 1 0
1 0 1 0 3 2 10 20 0011 0100 1 0
1 0 1 1 5 5 12 30 1000 0001 1 0
1 0 1 2 0 0 0 0 0101 1010 1 0
1 0 1 3 8 8 16 40 1100 0010 1 0
0 0 1 1 0 0 0 0 0000 0000 0 0
1 1 0 0 0 0 0 0 0000 0000 0 0
0 1 1 2 0 0 0 0 0000 0000 0 0
1 0 0 0 12 0 0 0 1111 0000 1 0
1 0 0 0 13 0 0 0 1111 0000 0 1
1 0 0 0 15 0 0 0 1000 0000 1 0
1 0 0 0 15 0 0 0 1001 0000 0 1
1 0 0 0 16 0 0 0 0000 0000 1 0
1 0 0 0 16 0 0 0 0001 0000 0 1
1 0 0 0 0 12 0 0 0000 1111 1 0
1 0 0 0 0 13 0 0 0000 1111 0 1
1 0 1 3 0 14 0 0 0000 0110 1 0
1 0 1 3 0 14 0 0 0000 0111 0 1
1 0 0 0 0 16 0 0 1111 0000 1 0
1 0 0 0 16 16 0 0 0000 0000 1 0
1 0 0 0 0 0 28 0 0000 0000 1 0
1 0 0 0 0 0 29 0 0000 0000 0 1
1 0 0 0 0 0 32 0 0000 0000 0 1
1 0 0 0 0 0 0 60 0000 0000 1 0
1 0 0 0 0 0 0 61 0000 0000 0 1
1 0 0 0 0 0 0 64 0000 0000 0 1
0 0 0 0 0 0 29 0 0000 0000 0 1
0 0 0 0 13 0 0 0 1111 0000 0 1
1 1 0 0 0 0 0 61 0000 0000 0 1
0 1 0 0 0 13 0 0 0000 1111 0 1
1 0 1 0 14 14 28 60 0011 1100 1 0
1 0 1 1 14 14 28 60 0111 1000 0 1
1 0 1 2 14 15 28 60 0011 1100 0 1
1 0 1 3 14 14 28 61 0011 1100 0 1
1 0 1 0 14 14 29 60 0011 1100 0 1
1 0 1 0 2 3 4 5 0001 0010 1 0
1 0 1 1 6 7 8 9 0100 1000 1 0
0 0 1 2 1 1 1 1 1000 0100 0 0
1 0 1 3 9 9 20 50 0000 0000 1 0
